//--- sim.f
tiny16_pkg.sv
tiny16_alu.sv
tiny16_regfile.sv
tiny16_core.sv
tiny16_mem.sv
tiny16_ctrl_regs.sv
tiny16_top.sv
tb_tiny16_checker.sv
tb_tiny16_assert.sv
tb_tiny16.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the tiny16 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_tiny16 -o tb_tiny16
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_tiny16 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

//--- tb_tiny16.sv
`timescale 1ns/10ps
module tb_tiny16;
    import tiny16_pkg::*;

    localparam int    NUM_ROWS = 12;
    localparam word_t IRQ_VEC  = 16'h0040;
    localparam word_t POISON   = 16'hdead;
    localparam word_t HLT      = {OP_HLT, 12'h000};

    logic  clk;
    logic  reset;
    logic  psel, penable, pwrite;
    word_t paddr, pwdata, prdata;
    logic  pready, pslverr;
    logic [31:0] lfsr_state;

    string row_name [NUM_ROWS];
    word_t row_prog [NUM_ROWS][8];
    word_t row_load [NUM_ROWS];
    word_t row_res [NUM_ROWS];
    word_t row_exp [NUM_ROWS];
    word_t row_status [NUM_ROWS];
    logic  row_irq [NUM_ROWS];
    logic  row_chk_status [NUM_ROWS];

    tiny16_top #(.MEM_WORDS(1024), .IRQ_VECTOR(IRQ_VEC)) dut (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    tb_tiny16_checker u_checker (
        .clk     (clk),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pready  (pready),
        .pslverr (pslverr),
        .prdata  (prdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t enc_ldi(input logic [3:0] rd, input logic [7:0] imm);
        return {OP_LDI, rd, imm};
    endfunction

    function automatic word_t enc_alu(input logic [3:0] rd, input logic [3:0] rs,
                                      input logic [3:0] op);
        return {OP_ALU, rd, rs, op};
    endfunction

    function automatic word_t enc_mem(input opcode_t opc, input logic [3:0] rd,
                                      input logic [3:0] rs);
        return {opc, rd, rs, 4'h0};
    endfunction

    // Mask order is carry, zero, negative
    function automatic word_t enc_br(input logic [2:0] mask, input logic inv,
                                     input logic [7:0] off);
        return {OP_BR, mask, inv, off};
    endfunction

    function automatic word_t mem_addr(input word_t w);
        return 16'h1000 | (w << 2);
    endfunction

    function automatic word_t reg_addr(input logic [1:0] off);
        return {12'h000, off, 2'b00};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
    endfunction

    task automatic rand_byte(output logic [7:0] v);
        v = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
    endtask

    task automatic put_row(input int r, input string name, input word_t exp,
                           input logic irq, input logic chk, input word_t st);
        row_name[r]       = name;
        row_load[r]       = word_t'(16'h0080 + 8 * r);
        row_res[r]        = word_t'(16'h00e0 + r);
        row_exp[r]        = exp;
        row_irq[r]        = irq;
        row_chk_status[r] = chk;
        row_status[r]     = st;
    endtask

    task automatic build_table();
        logic [7:0]  a, b;
        logic [7:0]  res;
        word_t       p;
        logic [31:0] q;
        logic [3:0]  ops [4];
        string       names [4];
        word_t       exp;
        logic        zero_case, inv;
        ops   = '{ALU_ADD, ALU_SUB, ALU_XOR, ALU_SHL};
        names = '{"alu_add", "alu_sub", "alu_xor", "alu_shl"};
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int k = 0; k < 8; k++) begin
                row_prog[r][k] = HLT;
            end
        end
        for (int i = 0; i < 4; i++) begin
            rand_byte(a);
            rand_byte(b);
            case (i)
                0:       exp = word_t'({8'h00, a} + {8'h00, b});
                1:       exp = word_t'({8'h00, a} - {8'h00, b});
                2:       exp = {8'h00, a ^ b};
                default: exp = {7'h00, a, 1'b0};
            endcase
            put_row(i, names[i], exp, 1'b0, 1'b0, '0);
            res = row_res[i][7:0];
            row_prog[i][0] = enc_ldi(4'd1, a);
            row_prog[i][1] = enc_ldi(4'd2, b);
            row_prog[i][2] = enc_ldi(4'd3, res);
            row_prog[i][3] = enc_alu(4'd1, 4'd2, ops[i]);
            row_prog[i][4] = enc_mem(OP_ST, 4'd1, 4'd3);
        end
        // Squaring the first product gives a nonzero high word in r6
        rand_byte(a);
        rand_byte(b);
        p = {8'h00, a} * {8'h00, b};
        q = {16'h0000, p} * {16'h0000, p};
        put_row(4, "alu_mul_hi", q[31:16], 1'b0, 1'b0, '0);
        row_prog[4][0] = enc_ldi(4'd5, a);
        row_prog[4][1] = enc_ldi(4'd1, b);
        row_prog[4][2] = enc_ldi(4'd3, row_res[4][7:0]);
        row_prog[4][3] = enc_alu(4'd5, 4'd1, ALU_MUL);
        row_prog[4][4] = enc_alu(4'd5, 4'd5, ALU_MUL);
        row_prog[4][5] = enc_mem(OP_ST, 4'd6, 4'd3);
        rand_byte(a);
        put_row(5, "ld_st", {8'h00, a}, 1'b0, 1'b0, '0);
        row_prog[5][0] = enc_ldi(4'd1, a);
        row_prog[5][1] = enc_ldi(4'd2, 8'hf0);
        row_prog[5][2] = enc_mem(OP_ST, 4'd1, 4'd2);
        row_prog[5][3] = enc_mem(OP_LD, 4'd4, 4'd2);
        row_prog[5][4] = enc_ldi(4'd3, row_res[5][7:0]);
        row_prog[5][5] = enc_mem(OP_ST, 4'd4, 4'd3);
        // A taken branch skips the marker store and leaves the poison word
        for (int i = 0; i < 4; i++) begin
            zero_case = (i < 2);
            inv       = i[0];
            exp       = (zero_case ^ inv) ? POISON : 16'h0011;
            case (i)
                0:       put_row(6 + i, "br_zero", exp, 1'b0, 1'b0, '0);
                1:       put_row(6 + i, "br_zero_inv", exp, 1'b0, 1'b0, '0);
                2:       put_row(6 + i, "br_nonzero", exp, 1'b0, 1'b0, '0);
                default: put_row(6 + i, "br_nonzero_inv", exp, 1'b0, 1'b0, '0);
            endcase
            row_prog[6 + i][0] = enc_ldi(4'd1, 8'd5);
            row_prog[6 + i][1] = enc_ldi(4'd2, zero_case ? 8'd5 : 8'd6);
            row_prog[6 + i][2] = enc_ldi(4'd3, row_res[6 + i][7:0]);
            row_prog[6 + i][3] = enc_alu(4'd1, 4'd2, ALU_SUB);
            row_prog[6 + i][4] = enc_br(3'b010, inv, 8'd2);
            row_prog[6 + i][5] = enc_ldi(4'd4, 8'h11);
            row_prog[6 + i][6] = enc_mem(OP_ST, 4'd4, 4'd3);
        end
        put_row(10, "illegal_op", 16'h005a, 1'b0, 1'b1, 16'h0006);
        row_prog[10][0] = enc_ldi(4'd1, 8'h5a);
        row_prog[10][1] = enc_ldi(4'd3, row_res[10][7:0]);
        row_prog[10][2] = enc_mem(OP_ST, 4'd1, 4'd3);
        row_prog[10][3] = 16'hf000;
        row_prog[10][4] = enc_ldi(4'd1, 8'h00);
        row_prog[10][5] = enc_mem(OP_ST, 4'd1, 4'd3);
        // Main loop spins until the handler leaves 0x77 at the result word
        put_row(11, "irq_handler", 16'h0077, 1'b1, 1'b1, 16'h0002);
        row_prog[11][0] = enc_ldi(4'd3, row_res[11][7:0]);
        row_prog[11][1] = enc_ldi(4'd5, 8'h77);
        row_prog[11][2] = enc_mem(OP_LD, 4'd4, 4'd3);
        row_prog[11][3] = enc_alu(4'd4, 4'd5, ALU_SUB);
        row_prog[11][4] = enc_br(3'b010, 1'b1, 8'hfd);
    endtask

    task automatic apb_xfer(input logic wr, input word_t addr, input word_t wdata,
                            output word_t rdata);
        int waits;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        waits   = 0;
        @(posedge clk);
        while (!pready && waits < 64) begin
            waits++;
            @(posedge clk);
        end
        rdata = prdata;
        if (!pready) begin
            u_checker.note_failure($sformatf("APB transfer to %h got no pready", addr));
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input word_t addr, input word_t data);
        word_t unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input word_t addr, output word_t data);
        apb_xfer(1'b0, addr, '0, data);
    endtask

    task automatic check_read(input string name, input word_t addr, input word_t exp);
        word_t d;
        u_checker.arm(name, exp, 1'b0);
        apb_read(addr, d);
    endtask

    task automatic run_row(input int r);
        word_t st;
        int    polls;
        apb_write(reg_addr(REG_CTRL), 16'h0000);
        apb_write(mem_addr(row_res[r]), POISON);
        if (row_irq[r]) begin
            apb_write(mem_addr(IRQ_VEC), enc_ldi(4'd6, 8'h77));
            apb_write(mem_addr(IRQ_VEC + 16'd1), enc_ldi(4'd7, row_res[r][7:0]));
            apb_write(mem_addr(IRQ_VEC + 16'd2), enc_mem(OP_ST, 4'd6, 4'd7));
            apb_write(mem_addr(IRQ_VEC + 16'd3), {OP_RETI, 12'h000});
        end
        for (int k = 0; k < 8; k++) begin
            apb_write(mem_addr(row_load[r] + word_t'(k)), row_prog[r][k]);
        end
        apb_write(reg_addr(REG_START), row_load[r]);
        apb_write(reg_addr(REG_CTRL), 16'h0001);
        if (row_irq[r]) begin
            apb_write(reg_addr(REG_IRQ), 16'h0001);
        end
        polls = 0;
        st    = '0;
        while (!st[1] && polls < 100) begin
            apb_read(reg_addr(REG_STATUS), st);
            polls++;
        end
        if (!st[1]) begin
            u_checker.note_failure($sformatf("%s: core did not halt", row_name[r]));
        end
        check_read(row_name[r], mem_addr(row_res[r]), row_exp[r]);
        if (row_chk_status[r]) begin
            check_read(row_name[r], reg_addr(REG_STATUS), row_status[r]);
        end
        u_checker.end_test(row_name[r]);
    endtask

    initial begin
        word_t d;
        reset      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lfsr_state = 32'h2aab_48b0;
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;

        u_checker.arm("reset_state", 16'h0000, 1'b0);
        apb_read(reg_addr(REG_CTRL), d);
        u_checker.arm("reset_state", 16'h0000, 1'b0);
        apb_read(reg_addr(REG_STATUS), d);
        u_checker.arm("reset_state", 16'h0000, 1'b1);
        apb_read(16'h0010, d); // Offset outside the register map
        u_checker.end_test("reset_state");

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        u_checker.report();
        if (u_checker.tests_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Budget of 400 cycles for each table row
    initial begin
        repeat (NUM_ROWS * 400) @(posedge clk);
        $display("Error: simulation timed out before all tests finished");
        $display("tests failed");
        $finish;
    end

endmodule

//--- tb_tiny16_assert.sv
`timescale 1ns/10ps
module tb_tiny16_assert (
    input logic                 clk,
    input logic                 reset,
    input tiny16_pkg::mem_req_t mem_req,
    input logic                 halted,
    input logic                 irq_ack,
    input logic                 in_irq
);
    import tiny16_pkg::*;

    assert property (@(posedge clk) disable iff (!reset) !(mem_req.rd && mem_req.wr))
        else $error("Core memory request has rd and wr high together");

    // A halted core stays off the memory until run control restarts it
    assert property (@(posedge clk) disable iff (!reset) halted |-> !(mem_req.rd || mem_req.wr))
        else $error("Core made a memory request while halted");

    assert property (@(posedge clk) disable iff (!reset) irq_ack |-> !in_irq)
        else $error("Interrupt acknowledged while already in an interrupt");

endmodule

bind tiny16_core tb_tiny16_assert u_assert (
    .clk     (clk),
    .reset   (reset),
    .mem_req (mem_req),
    .halted  (halted),
    .irq_ack (irq_ack),
    .in_irq  (in_irq)
);

//--- tb_tiny16_checker.sv
`timescale 1ns/10ps
module tb_tiny16_checker (
    input logic              clk,
    input logic              psel,
    input logic              penable,
    input logic              pwrite,
    input logic              pready,
    input logic              pslverr,
    input tiny16_pkg::word_t prdata
);
    import tiny16_pkg::*;

    string cur_name;
    word_t exp_data;
    logic  exp_err;
    logic  armed        = 1'b0;
    int    test_errors  = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;

    // Arms a compare for the next completed APB read
    task automatic arm(input string name, input word_t data, input logic err);
        cur_name = name;
        exp_data = data;
        exp_err  = err;
        armed    = 1'b1;
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        test_errors++;
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            $display("PASS %s", name);
            tests_passed++;
        end else begin
            $display("FAIL %s with %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic report();
        $display("Summary: %0d passed, %0d failed", tests_passed, tests_failed);
    endtask

    always @(posedge clk) begin
        if (armed && psel && penable && pready && !pwrite) begin
            armed = 1'b0;
            if (pslverr !== exp_err) begin
                note_failure($sformatf("Mismatch in %s: pslverr expected %0b, actual %0b",
                                       cur_name, exp_err, pslverr));
            end else if (!exp_err && prdata !== exp_data) begin
                note_failure($sformatf("Mismatch in %s: expected %h, actual %h",
                                       cur_name, exp_data, prdata));
            end
        end
    end

endmodule

//--- tiny16_top.sv
`timescale 1ns/10ps
module tiny16_top #(
    parameter int                MEM_WORDS  = 1024,
    parameter tiny16_pkg::word_t IRQ_VECTOR = 16'h0040
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  tiny16_pkg::word_t paddr,
    input  tiny16_pkg::word_t pwdata,
    output tiny16_pkg::word_t prdata,
    output logic              pready,
    output logic              pslverr
);
    import tiny16_pkg::*;

    logic     run, irq, irq_ack;
    logic     running, halted, error, in_irq;
    word_t    start_pc;
    mem_req_t core_req, dbg_req;
    mem_rsp_t core_rsp, dbg_rsp;

    tiny16_ctrl_regs #(.MEM_WORDS(MEM_WORDS)) u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .run      (run),
        .start_pc (start_pc),
        .irq      (irq),
        .irq_ack  (irq_ack),
        .running  (running),
        .halted   (halted),
        .error    (error),
        .in_irq   (in_irq),
        .dbg_req  (dbg_req),
        .dbg_rsp  (dbg_rsp)
    );

    tiny16_core #(.IRQ_VECTOR(IRQ_VECTOR)) u_core (
        .clk      (clk),
        .reset    (reset),
        .run      (run),
        .start_pc (start_pc),
        .irq      (irq),
        .irq_ack  (irq_ack),
        .running  (running),
        .halted   (halted),
        .error    (error),
        .in_irq   (in_irq),
        .mem_req  (core_req),
        .mem_rsp  (core_rsp)
    );

    tiny16_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
        .clk      (clk),
        .reset    (reset),
        .core_req (core_req),
        .core_rsp (core_rsp),
        .dbg_req  (dbg_req),
        .dbg_rsp  (dbg_rsp)
    );

endmodule

//--- tiny16_ctrl_regs.sv
`timescale 1ns/10ps
module tiny16_ctrl_regs #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  tiny16_pkg::word_t    paddr,
    input  tiny16_pkg::word_t    pwdata,
    output tiny16_pkg::word_t    prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic                 run,
    output tiny16_pkg::word_t    start_pc,
    output logic                 irq,
    input  logic                 irq_ack,
    input  logic                 running,
    input  logic                 halted,
    input  logic                 error,
    input  logic                 in_irq,
    output tiny16_pkg::mem_req_t dbg_req,
    input  tiny16_pkg::mem_rsp_t dbg_rsp
);
    import tiny16_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    logic       win, access, bad_off, reg_wr, dbg_active;
    logic [1:0] offset;
    word_t      status, reg_rdata, win_addr;

    assign win      = paddr[12]; // Memory window
    assign access   = psel & penable;
    assign offset   = paddr[3:2];
    assign bad_off  = (paddr[11:4] != '0);
    assign reg_wr   = access & pwrite & ~win & ~bad_off;
    assign win_addr = word_t'(paddr[AW+1:2]);
    assign status   = {12'h000, in_irq, error, halted, running};

    always_comb begin
        case (offset)
            REG_CTRL:   reg_rdata = {15'h0000, run};
            REG_START:  reg_rdata = start_pc;
            REG_STATUS: reg_rdata = status;
            default:    reg_rdata = {15'h0000, irq};
        endcase
    end

    assign prdata  = win ? dbg_rsp.rdata : reg_rdata;
    assign pready  = access & (~win | dbg_rsp.ready);
    assign pslverr = access & ~win & bad_off;

    always_ff @(posedge clk) begin
        if (!reset) begin
            run        <= 1'b0;
            start_pc   <= '0;
            irq        <= 1'b0;
            dbg_active <= 1'b0;
        end else begin
            if (reg_wr && offset == REG_CTRL) begin
                run <= pwdata[0];
            end
            if (reg_wr && offset == REG_START) begin
                start_pc <= pwdata;
            end
            // A new request in the same cycle as the ack is kept
            if (irq_ack) begin
                irq <= 1'b0;
            end
            if (reg_wr && offset == REG_IRQ && pwdata[0]) begin
                irq <= 1'b1;
            end
            if (dbg_rsp.ready) begin
                dbg_active <= 1'b0;
            end else if (access & win) begin
                dbg_active <= 1'b1;
            end
        end
    end

    always_comb begin
        dbg_req.addr  = win_addr;
        dbg_req.wdata = pwdata;
        dbg_req.rd    = dbg_active & ~pwrite;
        dbg_req.wr    = dbg_active & pwrite;
    end

endmodule

//--- tiny16_mem.sv
`timescale 1ns/10ps
module tiny16_mem #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                 clk,
    input  logic                 reset,
    input  tiny16_pkg::mem_req_t core_req,
    output tiny16_pkg::mem_rsp_t core_rsp,
    input  tiny16_pkg::mem_req_t dbg_req,
    output tiny16_pkg::mem_rsp_t dbg_rsp
);
    import tiny16_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    word_t    mem [MEM_WORDS];
    word_t    rdata_q;
    mem_req_t sel;
    logic     core_go, dbg_go, accept;
    logic     core_rdy, dbg_rdy;

    assign core_go = core_req.rd | core_req.wr;
    assign dbg_go  = dbg_req.rd | dbg_req.wr;
    // Requesters still hold their request during the ready cycle
    assign accept  = ~core_rdy & ~dbg_rdy & (core_go | dbg_go);
    assign sel     = core_go ? core_req : dbg_req;

    always_ff @(posedge clk) begin
        if (!reset) begin
            core_rdy <= 1'b0;
            dbg_rdy  <= 1'b0;
        end else begin
            core_rdy <= accept & core_go;
            dbg_rdy  <= accept & ~core_go;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (sel.wr) begin
                mem[sel.addr[AW-1:0]] <= sel.wdata;
            end
            rdata_q <= mem[sel.addr[AW-1:0]];
        end
    end

    assign core_rsp.rdata = rdata_q;
    assign core_rsp.ready = core_rdy;
    assign dbg_rsp.rdata  = rdata_q;
    assign dbg_rsp.ready  = dbg_rdy;

endmodule

//--- tiny16_core.sv
`timescale 1ns/10ps
module tiny16_core #(
    parameter tiny16_pkg::word_t IRQ_VECTOR = 16'h0040
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run,
    input  tiny16_pkg::word_t    start_pc,
    input  logic                 irq,
    output logic                 irq_ack,
    output logic                 running,
    output logic                 halted,
    output logic                 error,
    output logic                 in_irq,
    output tiny16_pkg::mem_req_t mem_req,
    input  tiny16_pkg::mem_rsp_t mem_rsp
);
    import tiny16_pkg::*;

    core_state_t state;
    word_t       pc;
    word_t       ir;
    word_t       epc;
    word_t       hi_data;
    reg_idx_t    hi_idx;
    logic        hi_pend;
    logic        run_q;
    logic        fetch_busy;
    logic        flag_c, flag_z, flag_n;

    opcode_t     opcode;
    reg_idx_t    rd_idx, rs_idx;
    word_t       ra_data, rb_data;
    word_t       imm, br_off;
    word_t       alu_result, alu_hi;
    logic        alu_carry, alu_zero;
    logic [2:0]  br_mask;
    logic        br_taken, take_irq, run_rise;
    logic        rf_we;
    reg_idx_t    rf_idx;
    word_t       rf_data;

    assign opcode   = ir[15:12];
    assign rd_idx   = ir[11:8];
    assign rs_idx   = ir[7:4];
    assign imm      = {8'h00, ir[7:0]};
    assign br_off   = {{8{ir[7]}}, ir[7:0]};
    assign br_mask  = ir[11:9] & {flag_c, flag_z, flag_n};
    assign br_taken = (|br_mask) ^ ir[8];
    assign run_rise = run & ~run_q;

    // Interrupts are only taken before the fetch read has gone out
    assign take_irq = (state == FETCH) & run & irq & ~in_irq & ~fetch_busy;
    assign irq_ack  = take_irq;
    assign running  = (state != IDLE) && (state != HALTED);

    tiny16_alu u_alu (
        .op        (ir[3:0]),
        .a         (ra_data),
        .b         (rb_data),
        .result    (alu_result),
        .result_hi (alu_hi),
        .carry     (alu_carry),
        .zero      (alu_zero)
    );

    tiny16_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .ra_idx  (rd_idx),
        .rb_idx  (rs_idx),
        .ra_data (ra_data),
        .rb_data (rb_data),
        .we      (rf_we),
        .w_idx   (rf_idx),
        .w_data  (rf_data)
    );

    // The high product word goes in the cycle after EXEC, when the port is free
    always_comb begin
        rf_we   = 1'b0;
        rf_idx  = rd_idx;
        rf_data = alu_result;
        if (hi_pend) begin
            rf_we   = 1'b1;
            rf_idx  = hi_idx;
            rf_data = hi_data;
        end else if (state == EXEC && opcode == OP_ALU) begin
            rf_we = 1'b1;
        end else if (state == EXEC && opcode == OP_LDI) begin
            rf_we   = 1'b1;
            rf_data = imm;
        end else if (state == MEM_WAIT && opcode == OP_LD && mem_rsp.ready) begin
            rf_we   = 1'b1;
            rf_data = mem_rsp.rdata;
        end
    end

    always_comb begin
        mem_req = '0;
        if (state == FETCH) begin
            mem_req.addr = pc;
            mem_req.rd   = ~take_irq;
        end else if (state == MEM_WAIT) begin
            mem_req.addr  = rb_data;
            mem_req.wdata = ra_data;
            mem_req.rd    = (opcode == OP_LD);
            mem_req.wr    = (opcode == OP_ST);
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state      <= IDLE;
            pc         <= '0;
            run_q      <= 1'b0;
            fetch_busy <= 1'b0;
            hi_pend    <= 1'b0;
            halted     <= 1'b0;
            error      <= 1'b0;
            in_irq     <= 1'b0;
            flag_c     <= 1'b0;
            flag_z     <= 1'b0;
            flag_n     <= 1'b0;
        end else begin
            run_q   <= run;
            hi_pend <= 1'b0;
            if (!run) begin
                state      <= IDLE;
                fetch_busy <= 1'b0;
            end else if (run_rise) begin
                state      <= FETCH;
                pc         <= start_pc;
                halted     <= 1'b0;
                error      <= 1'b0;
                in_irq     <= 1'b0;
                fetch_busy <= 1'b0;
            end else begin
                case (state)
                    FETCH: begin
                        if (take_irq) begin
                            epc    <= pc;
                            pc     <= IRQ_VECTOR;
                            in_irq <= 1'b1;
                        end else if (mem_rsp.ready) begin
                            ir         <= mem_rsp.rdata;
                            pc         <= pc + 16'd1;
                            fetch_busy <= 1'b0;
                            state      <= DECODE;
                        end else begin
                            fetch_busy <= 1'b1;
                        end
                    end
                    DECODE: begin
                        case (opcode)
                            OP_NOP, OP_LDI, OP_ALU, OP_LD, OP_ST, OP_BR, OP_JMP, OP_RETI:
                                state <= EXEC;
                            OP_HLT: begin
                                state  <= HALTED;
                                halted <= 1'b1;
                            end
                            default: begin
                                state  <= HALTED;
                                halted <= 1'b1;
                                error  <= 1'b1;
                            end
                        endcase
                    end
                    EXEC: begin
                        state <= FETCH;
                        case (opcode)
                            OP_ALU: begin
                                flag_c <= alu_carry;
                                flag_z <= alu_zero;
                                flag_n <= alu_result[15];
                                if (ir[3:0] == ALU_MUL) begin
                                    hi_pend <= 1'b1;
                                    hi_idx  <= rd_idx + 4'd1;
                                    hi_data <= alu_hi;
                                end
                            end
                            OP_LD, OP_ST: state <= MEM_WAIT;
                            OP_BR: begin
                                if (br_taken) begin
                                    pc <= pc + br_off; // pc already points past the branch
                                end
                            end
                            OP_JMP: pc <= rb_data;
                            OP_RETI: begin
                                pc     <= epc;
                                in_irq <= 1'b0;
                            end
                            default: state <= FETCH;
                        endcase
                    end
                    MEM_WAIT: begin
                        if (mem_rsp.ready) begin
                            state <= FETCH;
                        end
                    end
                    default: state <= state; // IDLE and HALTED wait for run control
                endcase
            end
        end
    end

endmodule

//--- tiny16_regfile.sv
`timescale 1ns/10ps
module tiny16_regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  tiny16_pkg::reg_idx_t ra_idx,
    input  tiny16_pkg::reg_idx_t rb_idx,
    output tiny16_pkg::word_t    ra_data,
    output tiny16_pkg::word_t    rb_data,
    input  logic                 we,
    input  tiny16_pkg::reg_idx_t w_idx,
    input  tiny16_pkg::word_t    w_data
);
    import tiny16_pkg::*;

    word_t regs [16];

    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[w_idx] <= w_data;
        end
    end

    // Reads see the old value during a write to the same register
    assign ra_data = regs[ra_idx];
    assign rb_data = regs[rb_idx];

endmodule

//--- tiny16_alu.sv
`timescale 1ns/10ps
module tiny16_alu (
    input  tiny16_pkg::alu_op_t op,
    input  tiny16_pkg::word_t   a,
    input  tiny16_pkg::word_t   b,
    output tiny16_pkg::word_t   result,
    output tiny16_pkg::word_t   result_hi,
    output logic                carry,
    output logic                zero
);
    import tiny16_pkg::*;

    logic [16:0] sum;
    logic [31:0] prod;

    always_comb begin
        sum       = '0;
        prod      = '0;
        result    = '0;
        result_hi = '0;
        carry     = 1'b0;
        case (op)
            ALU_ADD: begin
                sum    = {1'b0, a} + {1'b0, b};
                result = sum[15:0];
                carry  = sum[16];
            end
            ALU_SUB: begin
                sum    = {1'b0, a} - {1'b0, b};
                result = sum[15:0];
                carry  = sum[16]; // Borrow
            end
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SHL: begin
                result = {a[14:0], 1'b0};
                carry  = a[15];
            end
            ALU_SHR: begin
                result = {1'b0, a[15:1]};
                carry  = a[0];
            end
            ALU_MUL: begin
                prod      = {16'h0000, a} * {16'h0000, b};
                result    = prod[15:0];
                result_hi = prod[31:16];
            end
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- tiny16_pkg.sv
package tiny16_pkg;

    typedef logic [15:0] word_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [3:0]  alu_op_t;

    // Opcodes in bits 15 to 12, anything above OP_RETI is illegal
    localparam opcode_t OP_NOP  = 4'h0;
    localparam opcode_t OP_LDI  = 4'h1;
    localparam opcode_t OP_ALU  = 4'h2;
    localparam opcode_t OP_LD   = 4'h3;
    localparam opcode_t OP_ST   = 4'h4;
    localparam opcode_t OP_BR   = 4'h5;
    localparam opcode_t OP_JMP  = 4'h6;
    localparam opcode_t OP_HLT  = 4'h7;
    localparam opcode_t OP_RETI = 4'h8;

    localparam alu_op_t ALU_ADD = 4'h0;
    localparam alu_op_t ALU_SUB = 4'h1;
    localparam alu_op_t ALU_AND = 4'h2;
    localparam alu_op_t ALU_OR  = 4'h3;
    localparam alu_op_t ALU_XOR = 4'h4;
    localparam alu_op_t ALU_SHL = 4'h5;
    localparam alu_op_t ALU_SHR = 4'h6;
    localparam alu_op_t ALU_MUL = 4'h7;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXEC,
        MEM_WAIT,
        HALTED
    } core_state_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  rd;
        logic  wr;
    } mem_req_t;

    typedef struct packed {
        word_t rdata;
        logic  ready;
    } mem_rsp_t;

    // Register offsets, taken from paddr[3:2]
    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_START  = 2'd1;
    localparam logic [1:0] REG_STATUS = 2'd2;
    localparam logic [1:0] REG_IRQ    = 2'd3;

endpackage
